// File: audio_front.f
design/audio_front_pkg.sv
design/sample_rate_strobe.sv
design/triangle_gen.sv
design/front_end_mux.sv
design/front_end_regs.sv
design/audio_front_top.sv
test/audio_front_sva.sv
test/audio_front_tb.sv

// File: design/audio_front_pkg.sv
`default_nettype none

package audio_front_pkg;

    // audio sample and triangle step, 24-bit two's complement
    typedef logic [23:0] sample_t;
    typedef logic [23:0] step_t;

    // output source select
    typedef enum logic [1:0] {
        src_pcm      = 2'd0,
        src_dc_pos   = 2'd1,
        src_dc_neg   = 2'd2,
        src_triangle = 2'd3
    } src_sel_t;

    // sample rate code and master clock divisor
    typedef logic [2:0]  rate_code_t;
    typedef logic [10:0] div_t;

    localparam rate_code_t rate_192k  = 3'd0;
    localparam rate_code_t rate_96k   = 3'd1;
    localparam rate_code_t rate_48k   = 3'd2;
    localparam rate_code_t rate_88k2  = 3'd3;
    localparam rate_code_t rate_44k1  = 3'd4;

    // strobe period is divisor + 1 master clocks at 49.152 MHz
    localparam div_t div_192k = 11'd255;
    localparam div_t div_96k  = 11'd511;
    localparam div_t div_48k  = 11'd1023;
    localparam div_t div_88k2 = 11'd556;
    localparam div_t div_44k1 = 11'd1114;

    // test levels
    localparam sample_t dc_pos_level    = 24'h7fff00;
    localparam sample_t dc_neg_level    = 24'h8000ff;
    localparam sample_t tri_upper_limit = 24'h7ffffe;

    // axi4-lite register map
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;

    localparam axi_addr_t addr_ctrl = 4'h0;
    localparam axi_addr_t addr_step = 4'h4;
    localparam axi_addr_t addr_rate = 4'h8;

    localparam logic [1:0] resp_okay = 2'b00;

    // read channel fsm
    typedef enum logic {
        rd_idle,
        rd_resp
    } reg_state_t;

endpackage

`default_nettype wire

// File: design/audio_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_front_top import audio_front_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // axi4-lite slave
    input  wire axi_addr_t s_awaddr,
    input  wire logic      s_awvalid,
    output logic           s_awready,
    input  wire axi_data_t s_wdata,
    input  wire logic      s_wvalid,
    output logic           s_wready,
    output logic [1:0]     s_bresp,
    output logic           s_bvalid,
    input  wire logic      s_bready,
    input  wire axi_addr_t s_araddr,
    input  wire logic      s_arvalid,
    output logic           s_arready,
    output axi_data_t      s_rdata,
    output logic [1:0]     s_rresp,
    output logic           s_rvalid,
    input  wire logic      s_rready,
    // pcm in from the receiver
    input  wire logic      l_pcm_valid,
    input  wire sample_t   l_pcm_data,
    input  wire logic      r_pcm_valid,
    input  wire sample_t   r_pcm_data,
    // samples out to the serializer
    output logic           l_out_valid,
    output sample_t        l_out_data,
    output logic           r_out_valid,
    output sample_t        r_out_data
);

    logic       run;
    src_sel_t   src_sel;
    step_t      tri_step;
    rate_code_t rate_code;
    logic       smp_strobe;
    sample_t    tri_value;

    //////////////////////////////////////////////////
    // control registers
    //////////////////////////////////////////////////

    front_end_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .run       (run),
        .src_sel   (src_sel),
        .tri_step  (tri_step),
        .rate_code (rate_code)
    );

    //////////////////////////////////////////////////
    // test signal path
    //////////////////////////////////////////////////

    sample_rate_strobe u_strobe (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .rate_code  (rate_code),
        .smp_strobe (smp_strobe)
    );

    triangle_gen u_tri (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .smp_strobe (smp_strobe),
        .tri_step   (tri_step),
        .tri_value  (tri_value)
    );

    // output stage
    front_end_mux u_mux (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .src_sel     (src_sel),
        .smp_strobe  (smp_strobe),
        .tri_value   (tri_value),
        .l_pcm_valid (l_pcm_valid),
        .r_pcm_valid (r_pcm_valid),
        .l_pcm_data  (l_pcm_data),
        .r_pcm_data  (r_pcm_data),
        .l_out_valid (l_out_valid),
        .r_out_valid (r_out_valid),
        .l_out_data  (l_out_data),
        .r_out_data  (r_out_data)
    );

endmodule

`default_nettype wire

// File: design/front_end_mux.sv
`timescale 1ns/1ps
`default_nettype none

module front_end_mux import audio_front_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     run,
    input  wire src_sel_t src_sel,
    input  wire logic     smp_strobe,
    input  wire sample_t  tri_value,
    input  wire logic     l_pcm_valid,
    input  wire logic     r_pcm_valid,
    input  wire sample_t  l_pcm_data,
    input  wire sample_t  r_pcm_data,
    output logic          l_out_valid,
    output logic          r_out_valid,
    output sample_t       l_out_data,
    output sample_t       r_out_data
);

    logic    pcm_mode;
    sample_t test_word;
    logic    l_take;
    logic    r_take;
    sample_t l_word;
    sample_t r_word;

    assign pcm_mode = (src_sel == src_pcm);

    // test signal word, shared by both channels
    always_comb begin
        case (src_sel)
            src_dc_pos:   test_word = dc_pos_level;
            src_dc_neg:   test_word = dc_neg_level;
            src_triangle: test_word = tri_value;
            default:      test_word = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // valid and data source per channel
    //////////////////////////////////////////////////

    // pcm mode follows each channel's own valid
    // test modes follow the sample strobe on both sides
    assign l_take = pcm_mode ? l_pcm_valid : smp_strobe;
    assign r_take = pcm_mode ? r_pcm_valid : smp_strobe;
    assign l_word = pcm_mode ? l_pcm_data : test_word;
    assign r_word = pcm_mode ? r_pcm_data : test_word;

    //////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////

    // data held between valids for the serializer
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            l_out_valid <= 1'b0;
            r_out_valid <= 1'b0;
            l_out_data  <= '0;
            r_out_data  <= '0;
        end else begin
            l_out_valid <= l_take;
            r_out_valid <= r_take;
            if (l_take) begin
                l_out_data <= l_word;
            end
            if (r_take) begin
                r_out_data <= r_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/front_end_regs.sv
`timescale 1ns/1ps
`default_nettype none

module front_end_regs import audio_front_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // write address and data
    input  wire axi_addr_t s_awaddr,
    input  wire logic      s_awvalid,
    output logic           s_awready,
    input  wire axi_data_t s_wdata,
    input  wire logic      s_wvalid,
    output logic           s_wready,
    // write response
    output logic [1:0]     s_bresp,
    output logic           s_bvalid,
    input  wire logic      s_bready,
    // read address and data
    input  wire axi_addr_t s_araddr,
    input  wire logic      s_arvalid,
    output logic           s_arready,
    output axi_data_t      s_rdata,
    output logic [1:0]     s_rresp,
    output logic           s_rvalid,
    input  wire logic      s_rready,
    // control fields
    output logic           run,
    output src_sel_t       src_sel,
    output step_t          tri_step,
    output rate_code_t     rate_code
);

    logic       aw_ready_q;
    logic       b_pending;
    logic       wr_hs;
    reg_state_t rd_state;
    axi_data_t  rd_word;

    //////////////////////////////////////////////////
    // write channel
    //////////////////////////////////////////////////

    assign s_awready = aw_ready_q;
    assign s_wready  = aw_ready_q;
    assign s_bvalid  = b_pending;
    assign s_bresp   = resp_okay;

    // address and data accepted together
    assign wr_hs = aw_ready_q && s_awvalid && s_wvalid;

    // one cycle ready pulse, none while a response waits
    always_ff @(posedge clk) begin
        if (reset) begin
            aw_ready_q <= 1'b0;
            b_pending  <= 1'b0;
        end else begin
            aw_ready_q <= s_awvalid && s_wvalid && !aw_ready_q && !b_pending;
            if (wr_hs) begin
                b_pending <= 1'b1;
            end else if (s_bready) begin
                b_pending <= 1'b0;
            end
        end
    end

    // register file, full word writes
    always_ff @(posedge clk) begin
        if (reset) begin
            run       <= 1'b0;
            src_sel   <= src_pcm;
            tri_step  <= '0;
            rate_code <= rate_48k;
        end else if (wr_hs) begin
            case (s_awaddr)
                addr_ctrl: begin
                    run     <= s_wdata[0];
                    src_sel <= src_sel_t'(s_wdata[2:1]);
                end
                addr_step: tri_step  <= s_wdata[23:0];
                addr_rate: rate_code <= s_wdata[2:0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // read channel
    //////////////////////////////////////////////////

    assign s_arready = (rd_state == rd_idle);
    assign s_rvalid  = (rd_state == rd_resp);
    assign s_rresp   = resp_okay;

    // read-back mux, unmapped reads zero
    always_comb begin
        rd_word = '0;
        case (s_araddr)
            addr_ctrl: rd_word[2:0]  = {src_sel, run};
            addr_step: rd_word[23:0] = tri_step;
            addr_rate: rd_word[2:0]  = rate_code;
            default:   rd_word       = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (s_arvalid) rd_state <= rd_resp;
                rd_resp: if (s_rready) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // read data captured at the address handshake
    always_ff @(posedge clk) begin
        if (rd_state == rd_idle && s_arvalid) begin
            s_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: design/sample_rate_strobe.sv
`timescale 1ns/1ps
`default_nettype none

module sample_rate_strobe import audio_front_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       run,
    input  wire rate_code_t rate_code,
    output logic            smp_strobe
);

    div_t div_sel;
    div_t cnt;

    // rate code to divisor, unused codes fall back to 48k
    always_comb begin
        case (rate_code)
            rate_192k: div_sel = div_192k;
            rate_96k:  div_sel = div_96k;
            rate_48k:  div_sel = div_48k;
            rate_88k2: div_sel = div_88k2;
            rate_44k1: div_sel = div_44k1;
            default:   div_sel = div_48k;
        endcase
    end

    //////////////////////////////////////////////////
    // divider counter
    //////////////////////////////////////////////////

    // >= so a smaller new divisor wraps at once
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            cnt        <= '0;
            smp_strobe <= 1'b0;
        end else if (cnt >= div_sel) begin
            cnt        <= '0;
            smp_strobe <= 1'b1;
        end else begin
            cnt        <= cnt + 11'd1;
            smp_strobe <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/triangle_gen.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_gen import audio_front_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  run,
    input  wire logic  smp_strobe,
    input  wire step_t tri_step,
    output sample_t    tri_value
);

    // high while ramping down
    logic dir_down;

    // one extra bit so the compares see no wrap
    logic [24:0] sum_up;
    logic [24:0] diff_dn;
    logic        up_ok;
    logic        dn_ok;

    assign sum_up  = {1'b0, tri_value} + {1'b0, tri_step};
    assign diff_dn = {1'b0, tri_value} - {1'b0, tri_step};

    // room left below the upper limit
    assign up_ok = sum_up < {1'b0, tri_upper_limit};
    // still above one step after the next subtract
    assign dn_ok = !diff_dn[24] && (diff_dn[23:0] > tri_step);

    //////////////////////////////////////////////////
    // ramp accumulator
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            tri_value <= '0;
            dir_down  <= 1'b0;
        end else if (smp_strobe) begin
            if (!dir_down) begin
                if (up_ok) begin
                    tri_value <= sum_up[23:0];
                end else begin
                    // top reached, turn down
                    tri_value <= diff_dn[23:0];
                    dir_down  <= 1'b1;
                end
            end else begin
                if (dn_ok) begin
                    tri_value <= diff_dn[23:0];
                end else begin
                    // bottom reached, turn up
                    tri_value <= sum_up[23:0];
                    dir_down  <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/audio_front_sva.sv
`timescale 1ns/1ps
`default_nettype none

module audio_front_sva import audio_front_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       run,
    input  wire logic [1:0] src_sel,
    input  wire logic       l_out_valid,
    input  wire logic       r_out_valid,
    input  wire logic       bvalid,
    input  wire logic       bready,
    input  wire logic       rvalid,
    input  wire logic       rready
);

    // failure count, read back by the testbench
    int fail_cnt = 0;

    //////////////////////////////////////////////////
    // output stage rules
    //////////////////////////////////////////////////

    // outputs clear one cycle after run drops
    a_run_off: assert property (@(posedge clk) disable iff (reset)
        !run |=> (!l_out_valid && !r_out_valid))
        else begin
            fail_cnt++;
            $error("out valid high one cycle after run low");
        end

    // test modes share the strobe on both channels
    a_valid_pair: assert property (@(posedge clk) disable iff (reset)
        (src_sel != src_pcm) |=> (l_out_valid == r_out_valid))
        else begin
            fail_cnt++;
            $error("left and right valid differ in a test mode");
        end

    //////////////////////////////////////////////////
    // bus response rules
    //////////////////////////////////////////////////

    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        (bvalid && !bready) |=> bvalid)
        else begin
            fail_cnt++;
            $error("bvalid dropped before bready");
        end

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        (rvalid && !rready) |=> rvalid)
        else begin
            fail_cnt++;
            $error("rvalid dropped before rready");
        end

endmodule

// output stage, bus side tied idle
bind front_end_mux audio_front_sva u_sva_mux (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .src_sel     (src_sel),
    .l_out_valid (l_out_valid),
    .r_out_valid (r_out_valid),
    .bvalid      (1'b0),
    .bready      (1'b1),
    .rvalid      (1'b0),
    .rready      (1'b1)
);

// register block, audio side tied idle
bind front_end_regs audio_front_sva u_sva_regs (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .src_sel     (src_sel),
    .l_out_valid (1'b0),
    .r_out_valid (1'b0),
    .bvalid      (s_bvalid),
    .bready      (s_bready),
    .rvalid      (s_rvalid),
    .rready      (s_rready)
);

`default_nettype wire

// File: test/audio_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_front_tb import audio_front_pkg::*; ();

    typedef struct {
        src_sel_t   src;
        step_t      step;
        rate_code_t rate;
        int         count;
    } row_t;

    // source, triangle step, rate code, samples per channel
    row_t rows [9] = '{
        '{src_pcm,      24'h000000, 3'd2, 40},
        '{src_dc_pos,   24'h000000, 3'd0, 8},
        '{src_dc_neg,   24'h000000, 3'd1, 8},
        '{src_dc_pos,   24'h000000, 3'd2, 4},
        '{src_dc_neg,   24'h000000, 3'd3, 4},
        '{src_dc_pos,   24'h000000, 3'd4, 4},
        '{src_dc_neg,   24'h000000, 3'd6, 4},
        '{src_triangle, 24'h02aaaa, 3'd0, 150},
        '{src_triangle, 24'h100000, 3'd1, 40}
    };

    // top of the ramp model
    localparam int ramp_top = 32'h007f_fffe;

    logic        clk = 1'b0;
    logic        reset;
    axi_addr_t   s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    axi_data_t   s_wdata;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    axi_addr_t   s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    axi_data_t   s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic        l_pcm_valid;
    sample_t     l_pcm_data;
    logic        r_pcm_valid;
    sample_t     r_pcm_data;
    logic        l_out_valid;
    sample_t     l_out_data;
    logic        r_out_valid;
    sample_t     r_out_data;

    int          errors = 0;
    int          checks = 0;
    int          cyc = 0;
    int          run_cyc = 0;
    logic [31:0] seed = 32'h8144_d56e;
    // triangle reference state
    int          model_ramp;
    logic        model_down;

    audio_front_top u_dut (.*);

    always #5 clk = ~clk;

    // rising edge counter read 1 ns after each edge
    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // strobe divisor per rate code with unused codes as 48k
    function automatic int expected_div(input rate_code_t code);
        case (code)
            3'd0: return 255;
            3'd1: return 511;
            3'd3: return 556;
            3'd4: return 1114;
            default: return 1023;
        endcase
    endfunction

    // bits that each register keeps
    function automatic axi_data_t field_mask(input axi_addr_t addr);
        case (addr)
            addr_ctrl: return 32'h0000_0007;
            addr_step: return 32'h00ff_ffff;
            addr_rate: return 32'h0000_0007;
            default:   return 32'h0000_0000;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("error %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timed out waiting for %s", what);
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // ramp moves one step and turns at the limits
    task automatic step_ramp_model(input int step);
        if (!model_down) begin
            if (model_ramp + step < ramp_top) begin
                model_ramp = model_ramp + step;
            end else begin
                model_ramp = model_ramp - step;
                model_down = 1'b1;
            end
        end else begin
            if (model_ramp - step > step) begin
                model_ramp = model_ramp - step;
            end else begin
                model_ramp = model_ramp + step;
                model_down = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // axi4-lite master
    //////////////////////////////////////////////////

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
        int n;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        while (!s_awready && n < 100) begin
            next_cycle();
            n++;
        end
        checks++;
        if (!s_awready) begin
            report_timeout("awready");
        end else if (s_wready !== 1'b1) begin
            // wready rises together with awready
            report_mismatch("s_wready", 1'b1, s_wready);
        end
        // register updates on the handshake edge
        next_cycle();
        run_cyc   = cyc;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        // both readies last one cycle only
        if ({s_awready, s_wready} !== 2'b00)
            report_mismatch("s_awready s_wready", 2'b00, {s_awready, s_wready});
        n = 0;
        while (!s_bvalid && n < 100) begin
            next_cycle();
            n++;
        end
        checks++;
        if (!s_bvalid) report_timeout("bvalid");
        if (s_bresp !== 2'b00) report_mismatch("bresp", 2'b00, s_bresp);
        // bready stays high so the response goes on this edge
        next_cycle();
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        int n;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        while (!s_arready && n < 100) begin
            next_cycle();
            n++;
        end
        if (!s_arready) report_timeout("arready");
        next_cycle();
        s_arvalid = 1'b0;
        n = 0;
        while (!s_rvalid && n < 100) begin
            next_cycle();
            n++;
        end
        checks++;
        if (!s_rvalid) report_timeout("rvalid");
        if (s_rresp !== 2'b00) report_mismatch("rresp", 2'b00, s_rresp);
        data = s_rdata;
        next_cycle();
    endtask

    //////////////////////////////////////////////////
    // per row checks
    //////////////////////////////////////////////////

    // pass-through with each channel on its own random gaps
    task automatic check_pcm_row(input int count);
        int      l_seen = 0;
        int      r_seen = 0;
        int      l_gap = 0;
        int      r_gap = 0;
        int      t = 0;
        logic    l_prev_v = 1'b0;
        logic    r_prev_v = 1'b0;
        sample_t l_prev_d = '0;
        sample_t r_prev_d = '0;
        sample_t l_exp = '0;
        sample_t r_exp = '0;
        logic [31:0] rnd;
        while ((l_seen < count || r_seen < count) && t < count * 16) begin
            // outputs carry the inputs of one cycle earlier
            checks++;
            if (l_out_valid !== l_prev_v) report_mismatch("l_out_valid", l_prev_v, l_out_valid);
            if (r_out_valid !== r_prev_v) report_mismatch("r_out_valid", r_prev_v, r_out_valid);
            if (l_prev_v) begin
                l_exp = l_prev_d;
                l_seen++;
            end
            if (r_prev_v) begin
                r_exp = r_prev_d;
                r_seen++;
            end
            // data holds between valids
            if (l_out_data !== l_exp) report_mismatch("l_out_data", l_exp, l_out_data);
            if (r_out_data !== r_exp) report_mismatch("r_out_data", r_exp, r_out_data);
            // junk data on idle cycles too
            rnd = next_rand();
            l_pcm_data  = rnd[23:0];
            l_pcm_valid = (l_gap == 0);
            l_gap       = l_pcm_valid ? int'(rnd[26:24]) : l_gap - 1;
            rnd = next_rand();
            r_pcm_data  = rnd[23:0];
            r_pcm_valid = (r_gap == 0);
            r_gap       = r_pcm_valid ? int'(rnd[29:27]) : r_gap - 1;
            l_prev_v = l_pcm_valid;
            r_prev_v = r_pcm_valid;
            l_prev_d = l_pcm_data;
            r_prev_d = r_pcm_data;
            next_cycle();
            t++;
        end
        if (l_seen < count || r_seen < count) report_timeout("pcm samples");
        l_pcm_valid = 1'b0;
        r_pcm_valid = 1'b0;
    endtask

    // dc and triangle rows paced by the sample strobe
    task automatic check_test_row(input row_t row);
        int      div;
        int      t;
        int      last;
        sample_t exp;
        div        = expected_div(row.rate);
        last       = run_cyc;
        model_ramp = 0;
        model_down = 1'b0;
        for (int n = 0; n < row.count; n++) begin
            t = 0;
            do begin
                next_cycle();
                t++;
            end while (!l_out_valid && t < 2 * (div + 1));
            if (!l_out_valid) begin
                report_timeout("test signal valid");
                return;
            end
            checks++;
            if (n == 0 && cyc - run_cyc != div + 2)
                report_mismatch("first valid delay", div + 2, cyc - run_cyc);
            if (n > 0 && cyc - last != div + 1)
                report_mismatch("valid spacing", div + 1, cyc - last);
            last = cyc;
            case (row.src)
                src_dc_pos: exp = 24'h7fff00;
                src_dc_neg: exp = 24'h8000ff;
                default:    exp = model_ramp[23:0];
            endcase
            if (row.src == src_triangle) step_ramp_model(int'(row.step));
            if (r_out_valid !== 1'b1) report_mismatch("r_out_valid", 1'b1, r_out_valid);
            if (l_out_data !== exp) report_mismatch("l_out_data", exp, l_out_data);
            if (r_out_data !== exp) report_mismatch("r_out_data", exp, r_out_data);
        end
    endtask

    // outputs stay silent once run is cleared
    task automatic check_run_off(input src_sel_t src);
        axi_write(addr_ctrl, {29'h0, src, 1'b0});
        for (int t = 0; t < 2000; t++) begin
            checks++;
            if ({l_out_valid, r_out_valid} !== 2'b00)
                report_mismatch("out_valid", 2'b00, {l_out_valid, r_out_valid});
            if (l_out_data !== '0) report_mismatch("l_out_data", 0, l_out_data);
            if (r_out_data !== '0) report_mismatch("r_out_data", 0, r_out_data);
            next_cycle();
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        axi_addr_t reg_addr [5] = '{addr_ctrl, addr_step, addr_rate, 4'hc, 4'h2};
        axi_data_t reg_data [5] = '{32'hffff_fffe, 32'hdead_beef, 32'h5555_5555,
                                    32'h1234_5678, 32'hffff_ffff};
        axi_data_t rd;
        int        sva_fails;
        reset       = 1'b1;
        s_awaddr    = '0;
        s_awvalid   = 1'b0;
        s_wdata     = '0;
        s_wvalid    = 1'b0;
        s_bready    = 1'b1;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b1;
        l_pcm_valid = 1'b0;
        l_pcm_data  = '0;
        r_pcm_valid = 1'b0;
        r_pcm_data  = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values
        axi_read(addr_ctrl, rd);
        if (rd !== 32'h0) report_mismatch("rdata ctrl", 32'h0, rd);
        axi_read(addr_step, rd);
        if (rd !== 32'h0) report_mismatch("rdata step", 32'h0, rd);
        axi_read(addr_rate, rd);
        if (rd !== 32'h2) report_mismatch("rdata rate", 32'h2, rd);

        // write then read back each address
        for (int i = 0; i < 5; i++) begin
            axi_write(reg_addr[i], reg_data[i]);
            axi_read(reg_addr[i], rd);
            if (rd !== (reg_data[i] & field_mask(reg_addr[i])))
                report_mismatch("rdata", reg_data[i] & field_mask(reg_addr[i]), rd);
        end
        axi_write(addr_ctrl, 32'h0);

        for (int i = 0; i < 9; i++) begin
            axi_write(addr_step, {8'h00, rows[i].step});
            axi_write(addr_rate, {29'h0, rows[i].rate});
            // run last so the strobe starts from a known edge
            axi_write(addr_ctrl, {29'h0, rows[i].src, 1'b1});
            if (rows[i].src == src_pcm) begin
                check_pcm_row(rows[i].count);
            end else begin
                check_test_row(rows[i]);
            end
            check_run_off(rows[i].src);
        end

        sva_fails = u_dut.u_mux.u_sva_mux.fail_cnt + u_dut.u_regs.u_sva_regs.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
